//--- mips_core_macros.svh
`ifndef MIPS_CORE_MACROS_SVH
`define MIPS_CORE_MACROS_SVH

`define OP_REG  6'b000000
`define OP_J    6'b000010
`define OP_BGT  6'b000111
`define OP_ADDI 6'b001000
`define OP_SLTI 6'b001010
`define OP_ANDI 6'b001100
`define OP_ORI  6'b001101
`define OP_XORI 6'b001110
`define OP_LW   6'b100011
`define OP_SW   6'b101011
`define OP_HALT 6'b111111

`define FN_NOP  6'b000000
`define FN_SLLV 6'b000100
`define FN_JR   6'b001000
`define FN_ADD  6'b100000
`define FN_SUB  6'b100010
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_XOR  6'b100110
`define FN_SLT  6'b101010

`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

`define HALT_WORD 32'hffff_ffff

`define CMD_IMEM 1'b0
`define CMD_CTRL 1'b1

`endif

//--- mips_core_pkg.sv
package mips_core_pkg;

	// Data, instruction and byte address words
	typedef logic [31:0] word_t;

	// Register index into the 32 entry register file
	typedef logic [4:0] reg_addr_t;

	// Primary opcode field, instruction bits 31:26
	typedef logic [5:0] op_code_t;

	// Function field of register type instructions, also the ALU select
	typedef logic [5:0] funct_t;

	// Word index into instruction memory
	typedef logic [7:0] imem_addr_t;

	// One instruction is in flight at a time.
	// idle waits for the run bit, fetch loads the instruction register,
	// execute latches the trace entry and retire waits for the handshake.
	typedef enum logic [1:0] {
		idle,
		fetch,
		execute,
		retire
	} seq_state_t;

endpackage

//--- control_signals.sv
`timescale 1ns/1ns
`include "mips_core_macros.svh"

module control_signals import mips_core_pkg::*; (
	input op_code_t op_code,
	input funct_t alu_function,
	output logic reg_dst,
	output logic jump,
	output logic jump_reg,
	output logic branch,
	output logic mem_read,
	output logic mem_write,
	output logic mem_to_reg,
	output logic alu_src,
	output logic reg_write,
	output funct_t alu_op
);

	always_comb begin
		reg_dst = 1'b0;
		jump = 1'b0;
		jump_reg = 1'b0;
		branch = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_to_reg = 1'b0;
		alu_src = 1'b0;
		reg_write = 1'b0;
		alu_op = `FN_NOP;

		case (op_code)
			`OP_REG: begin
				reg_dst = 1'b1;
				case (alu_function)
					`FN_JR: begin
						jump = 1'b1;
						jump_reg = 1'b1;
					end
					`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_XOR, `FN_SLT, `FN_SLLV: begin
						alu_op = alu_function;
						reg_write = 1'b1;
					end
					default: begin
						alu_op = `FN_NOP; // NOP and unknown functions write nothing
					end
				endcase
			end
			`OP_J: begin
				jump = 1'b1;
			end
			`OP_BGT: begin
				branch = 1'b1;
				alu_op = `FN_SUB; // Taken test comes from the ALU compare
			end
			`OP_ADDI: begin
				alu_op = `FN_ADD;
				alu_src = 1'b1;
				reg_write = 1'b1;
			end
			`OP_SLTI: begin
				alu_op = `FN_SLT;
				alu_src = 1'b1;
				reg_write = 1'b1;
			end
			`OP_ANDI: begin
				alu_op = `FN_AND;
				alu_src = 1'b1;
				reg_write = 1'b1;
			end
			`OP_ORI: begin
				alu_op = `FN_OR;
				alu_src = 1'b1;
				reg_write = 1'b1;
			end
			`OP_XORI: begin
				alu_op = `FN_XOR;
				alu_src = 1'b1;
				reg_write = 1'b1;
			end
			`OP_LW: begin
				mem_read = 1'b1;
				mem_to_reg = 1'b1;
				alu_op = `FN_ADD; // Base plus offset
				alu_src = 1'b1;
				reg_write = 1'b1;
			end
			`OP_SW: begin
				mem_write = 1'b1;
				alu_op = `FN_ADD;
				alu_src = 1'b1;
			end
			default: begin
				alu_op = `FN_NOP; // HALT and unknown opcodes do nothing here
			end
		endcase
	end

endmodule

//--- alu.sv
`timescale 1ns/1ns
`include "mips_core_macros.svh"

module alu import mips_core_pkg::*; (
	input word_t a,
	input word_t b,
	input funct_t alu_op,
	output word_t result,
	output logic greater
);

	logic [32:0] diff;
	logic less;

	// Sign extended to 33 bits so the top bit is the signed compare
	assign diff = {a[31], a} - {b[31], b};
	assign less = diff[32];
	assign greater = !diff[32] && (diff[31:0] != 32'd0);

	always_comb begin
		case (alu_op)
			`FN_ADD:  result = a + b;
			`FN_SUB:  result = diff[31:0];
			`FN_AND:  result = a & b;
			`FN_OR:   result = a | b;
			`FN_XOR:  result = a ^ b;
			`FN_SLT:  result = {31'd0, less};
			`FN_SLLV: result = b << a[4:0]; // Shift amount comes from rs
			default:  result = 32'd0;
		endcase
	end

endmodule

//--- register_file.sv
`timescale 1ns/1ns

module register_file import mips_core_pkg::*; (
	input logic clk,
	input logic rst,
	input reg_addr_t ra_addr,
	input reg_addr_t rb_addr,
	output word_t ra_data,
	output word_t rb_data,
	input logic wr_en,
	input reg_addr_t wr_addr,
	input word_t wr_data
);

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (wr_en && (wr_addr != 5'd0)) begin
			regs[wr_addr] <= wr_data; // r0 stays zero
		end
	end

	assign ra_data = (ra_addr == 5'd0) ? 32'd0 : regs[ra_addr];
	assign rb_data = (rb_addr == 5'd0) ? 32'd0 : regs[rb_addr];

endmodule

//--- mips_datapath.sv
`timescale 1ns/1ns
`include "mips_core_macros.svh"

module mips_datapath import mips_core_pkg::*; (
	input logic clk,
	input logic rst,
	input logic run,
	input word_t start_pc,
	input logic imem_we,
	input imem_addr_t imem_waddr,
	input word_t imem_wdata,
	input logic reg_dst,
	input logic jump,
	input logic jump_reg,
	input logic branch,
	input logic mem_read,
	input logic mem_write,
	input logic mem_to_reg,
	input logic alu_src,
	input logic reg_write,
	input word_t alu_result,
	input logic alu_greater,
	input word_t ra_data,
	input word_t rb_data,
	output logic halt_done,
	output op_code_t op_code,
	output funct_t alu_function,
	output word_t alu_a,
	output word_t alu_b,
	output reg_addr_t ra_addr,
	output reg_addr_t rb_addr,
	output logic wr_en,
	output reg_addr_t wr_addr,
	output word_t wr_data,
	output logic retire_valid,
	input logic retire_ready,
	output word_t retire_pc,
	output word_t retire_instr,
	output logic retire_reg_write,
	output reg_addr_t retire_rd,
	output word_t retire_value,
	output logic retire_mem_write,
	output word_t retire_mem_addr,
	output word_t retire_mem_data
);

	seq_state_t state;
	word_t pc;
	word_t instr;
	word_t next_pc;
	logic halt_q;
	word_t imem [`IMEM_DEPTH];
	word_t dmem [`DMEM_DEPTH];
	word_t imm_ext;
	word_t pc_plus4;
	word_t pc_sel;
	word_t load_data;
	logic zero_ext;
	logic retire_fire;

	assign op_code = instr[31:26];
	assign alu_function = instr[5:0];
	assign ra_addr = instr[25:21];
	assign rb_addr = instr[20:16];

	// Logical immediates are zero extended, all others sign extended
	assign zero_ext = (op_code == `OP_ANDI) || (op_code == `OP_ORI) || (op_code == `OP_XORI);
	assign imm_ext = zero_ext ? {16'd0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

	assign alu_a = ra_data;
	assign alu_b = alu_src ? imm_ext : rb_data;
	assign pc_plus4 = pc + 32'd4;
	assign load_data = mem_read ? dmem[alu_result[9:2]] : 32'd0;

	always_comb begin
		pc_sel = pc_plus4;
		if (jump_reg) begin
			pc_sel = ra_data;
		end else if (jump) begin
			pc_sel = {pc_plus4[31:28], instr[25:0], 2'b00};
		end else if (branch && alu_greater) begin
			pc_sel = pc_plus4 + {imm_ext[29:0], 2'b00};
		end
	end

	// Architectural state changes only on the retire handshake
	assign retire_fire = retire_valid && retire_ready;
	assign wr_en = retire_fire && retire_reg_write;
	assign wr_addr = retire_rd;
	assign wr_data = retire_value;
	assign halt_done = retire_fire && halt_q;
	assign retire_pc = pc; // PC and instruction hold still until the handshake
	assign retire_instr = instr;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			pc <= 32'd0;
			retire_valid <= 1'b0;
			halt_q <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (run) begin
						pc <= start_pc;
						state <= fetch;
					end
				end
				fetch: begin
					state <= execute;
				end
				execute: begin
					retire_valid <= 1'b1;
					halt_q <= (op_code == `OP_HALT);
					state <= retire;
				end
				retire: begin
					if (retire_fire) begin
						retire_valid <= 1'b0;
						halt_q <= 1'b0;
						pc <= next_pc;
						state <= halt_q ? idle : fetch;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == fetch) begin
			instr <= imem[pc[9:2]];
		end
		if (state == execute) begin
			next_pc <= pc_sel;
			retire_reg_write <= reg_write;
			retire_rd <= reg_dst ? instr[15:11] : instr[20:16];
			retire_value <= mem_to_reg ? load_data : alu_result;
			retire_mem_write <= mem_write;
			retire_mem_addr <= alu_result;
			retire_mem_data <= rb_data;
		end
	end

	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_waddr] <= imem_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (retire_fire && retire_mem_write) begin
			dmem[retire_mem_addr[9:2]] <= retire_mem_data;
		end
	end

endmodule

//--- host_port_regs.sv
`timescale 1ns/1ns
`include "mips_core_macros.svh"

module host_port_regs import mips_core_pkg::*; (
	input logic clk,
	input logic rst,
	input logic cmd_valid,
	input logic cmd_kind,
	input imem_addr_t cmd_addr,
	input word_t cmd_data,
	output logic cmd_ready,
	input logic halt_done,
	output logic run,
	output word_t start_pc,
	output logic imem_we,
	output imem_addr_t imem_waddr,
	output word_t imem_wdata
);

	logic cmd_fire;
	logic ctrl_fire;
	logic imem_fire;

	assign cmd_ready = !run; // Commands are taken only while stopped
	assign cmd_fire = cmd_valid && cmd_ready;
	assign ctrl_fire = cmd_fire && (cmd_kind == `CMD_CTRL);
	assign imem_fire = cmd_fire && (cmd_kind == `CMD_IMEM);

	always_ff @(posedge clk) begin
		if (rst) begin
			run <= 1'b0;
			imem_we <= 1'b0;
		end else begin
			imem_we <= imem_fire;
			if (halt_done) begin
				run <= 1'b0;
			end else if (ctrl_fire) begin
				run <= cmd_data[0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (imem_fire) begin
			imem_waddr <= cmd_addr;
			imem_wdata <= cmd_data;
		end
		if (ctrl_fire) begin
			start_pc <= {cmd_data[31:2], 2'b00}; // Bit 0 is the run bit
		end
	end

endmodule

//--- mips_core_top.sv
`timescale 1ns/1ns

module mips_core_top import mips_core_pkg::*; (
	input logic clk,
	input logic rst,
	input logic cmd_valid,
	input logic cmd_kind,
	input imem_addr_t cmd_addr,
	input word_t cmd_data,
	output logic cmd_ready,
	output logic retire_valid,
	input logic retire_ready,
	output word_t retire_pc,
	output word_t retire_instr,
	output logic retire_reg_write,
	output reg_addr_t retire_rd,
	output word_t retire_value,
	output logic retire_mem_write,
	output word_t retire_mem_addr,
	output word_t retire_mem_data,
	output logic halted
);

	logic run;
	word_t start_pc;
	logic imem_we;
	imem_addr_t imem_waddr;
	word_t imem_wdata;
	op_code_t op_code;
	funct_t alu_function;
	funct_t alu_op;
	logic reg_dst;
	logic jump;
	logic jump_reg;
	logic branch;
	logic mem_read;
	logic mem_write;
	logic mem_to_reg;
	logic alu_src;
	logic reg_write;
	word_t alu_a;
	word_t alu_b;
	word_t alu_result;
	logic alu_greater;
	reg_addr_t ra_addr;
	reg_addr_t rb_addr;
	word_t ra_data;
	word_t rb_data;
	logic wr_en;
	reg_addr_t wr_addr;
	word_t wr_data;

	host_port_regs host_port_regs_inst (
		.clk(clk),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd_kind(cmd_kind),
		.cmd_addr(cmd_addr),
		.cmd_data(cmd_data),
		.cmd_ready(cmd_ready),
		.halt_done(halted), // The halt pulse also clears the run bit
		.run(run),
		.start_pc(start_pc),
		.imem_we(imem_we),
		.imem_waddr(imem_waddr),
		.imem_wdata(imem_wdata)
	);

	mips_datapath mips_datapath_inst (
		.clk(clk),
		.rst(rst),
		.run(run),
		.start_pc(start_pc),
		.imem_we(imem_we),
		.imem_waddr(imem_waddr),
		.imem_wdata(imem_wdata),
		.reg_dst(reg_dst),
		.jump(jump),
		.jump_reg(jump_reg),
		.branch(branch),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_to_reg(mem_to_reg),
		.alu_src(alu_src),
		.reg_write(reg_write),
		.alu_result(alu_result),
		.alu_greater(alu_greater),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.halt_done(halted),
		.op_code(op_code),
		.alu_function(alu_function),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.retire_valid(retire_valid),
		.retire_ready(retire_ready),
		.retire_pc(retire_pc),
		.retire_instr(retire_instr),
		.retire_reg_write(retire_reg_write),
		.retire_rd(retire_rd),
		.retire_value(retire_value),
		.retire_mem_write(retire_mem_write),
		.retire_mem_addr(retire_mem_addr),
		.retire_mem_data(retire_mem_data)
	);

	control_signals control_signals_inst (
		.op_code(op_code),
		.alu_function(alu_function),
		.reg_dst(reg_dst),
		.jump(jump),
		.jump_reg(jump_reg),
		.branch(branch),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_to_reg(mem_to_reg),
		.alu_src(alu_src),
		.reg_write(reg_write),
		.alu_op(alu_op)
	);

	alu alu_inst (
		.a(alu_a),
		.b(alu_b),
		.alu_op(alu_op),
		.result(alu_result),
		.greater(alu_greater)
	);

	register_file register_file_inst (
		.clk(clk),
		.rst(rst),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data)
	);

endmodule

//--- tb_mips_core_properties.sv
`timescale 1ns/1ns

module tb_mips_core_properties import mips_core_pkg::*; (
	input logic clk,
	input logic rst,
	input logic run,
	input logic cmd_ready,
	input logic retire_valid,
	input logic retire_ready,
	input word_t retire_pc,
	input word_t retire_instr,
	input logic retire_reg_write,
	input reg_addr_t retire_rd,
	input word_t retire_value,
	input logic retire_mem_write,
	input word_t retire_mem_addr,
	input word_t retire_mem_data,
	input logic halted
);

	int ready_fails = 0;
	int stable_fails = 0;
	int reset_fails = 0;
	int failures;

	assign failures = ready_fails + stable_fails + reset_fails; // Read by the testbench verdict

	// A pending trace entry means an instruction is in flight
	ready_while_running: assert property (@(posedge clk) disable iff (rst)
		retire_valid |-> !cmd_ready)
		else begin
			$error("cmd_ready is high while the core is running");
			ready_fails++;
		end

	retire_held: assert property (@(posedge clk) disable iff (rst)
		(retire_valid && !retire_ready) |=> (retire_valid && $stable(retire_pc)
		&& $stable(retire_instr) && $stable(retire_reg_write) && $stable(retire_rd)
		&& $stable(retire_value) && $stable(retire_mem_write) && $stable(retire_mem_addr)
		&& $stable(retire_mem_data)))
		else begin
			$error("Retire outputs changed while the trace port was stalled");
			stable_fails++;
		end

	reset_state: assert property (@(posedge clk)
		$past(rst) |-> (!run && !retire_valid && !halted && cmd_ready))
		else begin
			$error("Core state after reset is wrong");
			reset_fails++;
		end

endmodule

//--- tb_mips_core.sv
`timescale 1ns/1ns
`include "mips_core_macros.svh"

module tb_mips_core import mips_core_pkg::*; ();

	localparam int PROG1_RETIRES = 19;
	localparam int PROG2_RETIRES = 17;
	localparam int LOAD_CMDS = 19 + 18 + 2;
	localparam int LOAD_CYCLES = 4 * LOAD_CMDS + 16;
	localparam int CYCLE_LIMIT = (PROG1_RETIRES + PROG2_RETIRES) * 3 * 8 + LOAD_CYCLES;

	typedef struct packed {
		word_t pc;
		word_t instr;
		logic reg_write;
		reg_addr_t rd;
		word_t value;
		logic mem_write;
		word_t mem_addr;
		word_t mem_data;
		logic halt;
	} trace_t;

	logic clk = 1'b0;
	logic rst;
	logic cmd_valid;
	logic cmd_kind;
	imem_addr_t cmd_addr;
	word_t cmd_data;
	logic cmd_ready;
	logic retire_valid;
	logic retire_ready = 1'b1;
	word_t retire_pc;
	word_t retire_instr;
	logic retire_reg_write;
	reg_addr_t retire_rd;
	word_t retire_value;
	logic retire_mem_write;
	word_t retire_mem_addr;
	word_t retire_mem_data;
	logic halted;

	integer seed = 32'hba4e_d132;
	integer rnd;
	logic random_ready = 1'b0;
	int cycle = 0;
	int errors = 0;
	int checks = 0;
	int halt_count = 0;
	int run_retires;
	int expected_retires;
	int last_fire;
	logic first_in_run;
	logic ready_after_halt;
	word_t model_regs [32];
	word_t model_dmem [`DMEM_DEPTH];
	word_t model_imem [`IMEM_DEPTH];
	word_t model_pc;
	trace_t expected;
	word_t prog [$];

	always #2 clk = ~clk;

	mips_core_top mips_core_top_inst (
		.clk(clk),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd_kind(cmd_kind),
		.cmd_addr(cmd_addr),
		.cmd_data(cmd_data),
		.cmd_ready(cmd_ready),
		.retire_valid(retire_valid),
		.retire_ready(retire_ready),
		.retire_pc(retire_pc),
		.retire_instr(retire_instr),
		.retire_reg_write(retire_reg_write),
		.retire_rd(retire_rd),
		.retire_value(retire_value),
		.retire_mem_write(retire_mem_write),
		.retire_mem_addr(retire_mem_addr),
		.retire_mem_data(retire_mem_data),
		.halted(halted)
	);

	bind mips_core_top tb_mips_core_properties tb_mips_core_properties_inst (
		.clk(clk),
		.rst(rst),
		.run(run),
		.cmd_ready(cmd_ready),
		.retire_valid(retire_valid),
		.retire_ready(retire_ready),
		.retire_pc(retire_pc),
		.retire_instr(retire_instr),
		.retire_reg_write(retire_reg_write),
		.retire_rd(retire_rd),
		.retire_value(retire_value),
		.retire_mem_write(retire_mem_write),
		.retire_mem_addr(retire_mem_addr),
		.retire_mem_data(retire_mem_data),
		.halted(halted)
	);

	function automatic word_t reg_instr(funct_t fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
		return {`OP_REG, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t imm_instr(op_code_t op, reg_addr_t rs, reg_addr_t rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jump_instr(logic [25:0] target);
		return {`OP_J, target};
	endfunction

	// Instruction set model, one instruction per call
	function automatic trace_t model_step();
		trace_t t;
		word_t ins;
		word_t rs_v;
		word_t rt_v;
		word_t imm_s;
		word_t imm_z;
		word_t addr;
		word_t pc4;
		word_t npc;
		ins = model_imem[model_pc[9:2]];
		rs_v = model_regs[ins[25:21]];
		rt_v = model_regs[ins[20:16]];
		imm_s = {{16{ins[15]}}, ins[15:0]};
		imm_z = {16'd0, ins[15:0]};
		addr = rs_v + imm_s;
		pc4 = model_pc + 32'd4;
		npc = pc4;
		t = '0;
		t.pc = model_pc;
		t.instr = ins;
		t.rd = ins[20:16]; // Immediate forms write rt
		t.reg_write = 1'b1;
		case (ins[31:26])
			`OP_REG: begin
				t.rd = ins[15:11];
				case (ins[5:0])
					`FN_ADD: t.value = rs_v + rt_v;
					`FN_SUB: t.value = rs_v - rt_v;
					`FN_AND: t.value = rs_v & rt_v;
					`FN_OR: t.value = rs_v | rt_v;
					`FN_XOR: t.value = rs_v ^ rt_v;
					`FN_SLT: t.value = ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
					`FN_SLLV: t.value = rt_v << rs_v[4:0];
					`FN_JR: begin
						t.reg_write = 1'b0;
						npc = rs_v;
					end
					default: t.reg_write = 1'b0;
				endcase
			end
			`OP_ADDI: t.value = rs_v + imm_s;
			`OP_SLTI: t.value = ($signed(rs_v) < $signed(imm_s)) ? 32'd1 : 32'd0;
			`OP_ANDI: t.value = rs_v & imm_z;
			`OP_ORI: t.value = rs_v | imm_z;
			`OP_XORI: t.value = rs_v ^ imm_z;
			`OP_LW: t.value = model_dmem[addr[9:2]];
			`OP_SW: begin
				t.reg_write = 1'b0;
				t.mem_write = 1'b1;
				t.mem_addr = addr;
				t.mem_data = rt_v;
				model_dmem[addr[9:2]] = rt_v;
			end
			`OP_J: begin
				t.reg_write = 1'b0;
				npc = {pc4[31:28], ins[25:0], 2'b00};
			end
			`OP_BGT: begin
				t.reg_write = 1'b0;
				if ($signed(rs_v) > $signed(rt_v)) begin
					npc = pc4 + (imm_s << 2);
				end
			end
			`OP_HALT: begin
				t.reg_write = 1'b0;
				t.halt = 1'b1;
			end
			default: t.reg_write = 1'b0;
		endcase
		if (t.reg_write && (t.rd != 5'd0)) begin
			model_regs[t.rd] = t.value; // r0 stays zero even though the trace shows the write
		end
		model_pc = npc;
		return t;
	endfunction

	task automatic check_equal(input word_t actual, input word_t want, input string what);
		checks++;
		if (actual !== want) begin
			errors++;
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, want);
		end
	endtask

	task automatic send_cmd(input logic kind, input imem_addr_t addr, input word_t data);
		@(negedge clk);
		cmd_valid = 1'b1;
		cmd_kind = kind;
		cmd_addr = addr;
		cmd_data = data;
		while (!cmd_ready) begin
			@(negedge clk);
		end
		@(negedge clk); // Transfer happened on the edge in between
		cmd_valid = 1'b0;
	endtask

	task automatic load_program(input int base);
		foreach (prog[i]) begin
			send_cmd(`CMD_IMEM, imem_addr_t'(base + i), prog[i]);
		end
	endtask

	task automatic run_program(input word_t start_pc, input int retires);
		int target;
		target = halt_count + 1;
		expected_retires = retires;
		send_cmd(`CMD_CTRL, 8'd0, start_pc | 32'd1);
		wait (halt_count == target);
		@(negedge clk);
	endtask

	always @(negedge clk) begin
		if (random_ready) begin
			rnd = $random(seed);
			retire_ready = rnd[0];
		end else begin
			retire_ready = 1'b1;
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("Timeout: no HALT retired within %0d cycles", CYCLE_LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Compare process, the model follows the host commands it sees accepted
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				model_regs[i] = 32'd0;
			end
			first_in_run = 1'b1;
			ready_after_halt = 1'b0;
			run_retires = 0;
			last_fire = 0;
		end else begin
			if (ready_after_halt) begin
				check_equal(word_t'(cmd_ready), 32'd1, "cmd_ready after HALT");
				ready_after_halt = 1'b0;
			end
			if (cmd_valid && cmd_ready) begin
				if (cmd_kind == `CMD_IMEM) begin
					model_imem[cmd_addr] = cmd_data;
				end else begin
					model_pc = {cmd_data[31:2], 2'b00};
				end
			end
			if (retire_valid && retire_ready) begin
				expected = model_step();
				check_equal(retire_pc, expected.pc, "retire_pc");
				check_equal(retire_instr, expected.instr, "retire_instr");
				check_equal(word_t'(retire_reg_write), word_t'(expected.reg_write),
					"retire_reg_write");
				if (expected.reg_write) begin
					check_equal(word_t'(retire_rd), word_t'(expected.rd), "retire_rd");
					check_equal(retire_value, expected.value, "retire_value");
				end
				check_equal(word_t'(retire_mem_write), word_t'(expected.mem_write),
					"retire_mem_write");
				if (expected.mem_write) begin
					check_equal(retire_mem_addr, expected.mem_addr, "retire_mem_addr");
					check_equal(retire_mem_data, expected.mem_data, "retire_mem_data");
				end
				check_equal(word_t'(halted), word_t'(expected.halt), "halted");
				if (!random_ready && !first_in_run) begin
					check_equal(word_t'(cycle - last_fire), 32'd3, "retire spacing");
				end
				first_in_run = 1'b0;
				last_fire = cycle;
				run_retires++;
				if (expected.halt) begin
					check_equal(word_t'(run_retires), word_t'(expected_retires), "retire count");
					run_retires = 0;
					first_in_run = 1'b1;
					ready_after_halt = 1'b1;
					halt_count++;
				end
			end else begin
				check_equal(word_t'(halted), 32'd0, "halted outside a retire");
			end
		end
	end

	initial begin
		int assert_fails;
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd_kind = `CMD_IMEM;
		cmd_addr = 8'd0;
		cmd_data = 32'd0;
		expected_retires = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Arithmetic, logic, r0 writes and a store then load, ready held high
		prog = {};
		prog.push_back(imm_instr(`OP_ADDI, 5'd0, 5'd1, 16'd7));
		prog.push_back(imm_instr(`OP_ADDI, 5'd0, 5'd2, 16'hfffd));
		prog.push_back(reg_instr(`FN_ADD, 5'd3, 5'd1, 5'd2));
		prog.push_back(reg_instr(`FN_SUB, 5'd4, 5'd2, 5'd1));
		prog.push_back(reg_instr(`FN_SLT, 5'd5, 5'd2, 5'd1));
		prog.push_back(reg_instr(`FN_SLT, 5'd6, 5'd1, 5'd2));
		prog.push_back(reg_instr(`FN_SLLV, 5'd7, 5'd3, 5'd1));
		prog.push_back(reg_instr(`FN_AND, 5'd8, 5'd1, 5'd2));
		prog.push_back(reg_instr(`FN_OR, 5'd9, 5'd1, 5'd2));
		prog.push_back(reg_instr(`FN_XOR, 5'd10, 5'd1, 5'd2));
		prog.push_back(imm_instr(`OP_ANDI, 5'd2, 5'd11, 16'hff00));
		prog.push_back(imm_instr(`OP_ORI, 5'd0, 5'd12, 16'h8001));
		prog.push_back(imm_instr(`OP_XORI, 5'd2, 5'd13, 16'hffff));
		prog.push_back(imm_instr(`OP_SLTI, 5'd2, 5'd14, 16'hffff));
		prog.push_back(imm_instr(`OP_ADDI, 5'd1, 5'd0, 16'd5));
		prog.push_back(reg_instr(`FN_ADD, 5'd15, 5'd0, 5'd1));
		prog.push_back(imm_instr(`OP_SW, 5'd3, 5'd4, 16'h003c));
		prog.push_back(imm_instr(`OP_LW, 5'd3, 5'd16, 16'h003c));
		prog.push_back(`HALT_WORD);
		load_program(0);
		run_program(32'h0000_0000, PROG1_RETIRES);

		// Branches, jumps and a short loop on the carried over registers, random ready
		random_ready = 1'b1;
		prog = {};
		prog.push_back(imm_instr(`OP_BGT, 5'd1, 5'd2, 16'd1));
		prog.push_back(imm_instr(`OP_ADDI, 5'd0, 5'd20, 16'd99));
		prog.push_back(imm_instr(`OP_BGT, 5'd2, 5'd1, 16'd5));
		prog.push_back(jump_instr(26'd70));
		prog.push_back(imm_instr(`OP_ADDI, 5'd0, 5'd21, 16'd1));
		prog.push_back(imm_instr(`OP_ADDI, 5'd0, 5'd22, 16'd2));
		prog.push_back(imm_instr(`OP_ORI, 5'd0, 5'd23, 16'h0128));
		prog.push_back(reg_instr(`FN_JR, 5'd0, 5'd23, 5'd0));
		prog.push_back(imm_instr(`OP_ADDI, 5'd0, 5'd24, 16'd3));
		prog.push_back(imm_instr(`OP_ADDI, 5'd0, 5'd24, 16'd4));
		prog.push_back(32'd0);
		prog.push_back(reg_instr(`FN_ADD, 5'd25, 5'd16, 5'd3));
		prog.push_back(imm_instr(`OP_ADDI, 5'd0, 5'd26, 16'd3));
		prog.push_back(imm_instr(`OP_ADDI, 5'd26, 5'd26, 16'hffff));
		prog.push_back(imm_instr(`OP_BGT, 5'd26, 5'd0, 16'hfffe)); // Loops back twice
		prog.push_back(imm_instr(`OP_SW, 5'd0, 5'd25, 16'h0080));
		prog.push_back(imm_instr(`OP_LW, 5'd0, 5'd27, 16'h0080));
		prog.push_back(`HALT_WORD);
		load_program(64);
		run_program(32'h0000_0100, PROG2_RETIRES);

		repeat (2) @(negedge clk);
		assert_fails = mips_core_top_inst.tb_mips_core_properties_inst.failures;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, assert_fails);
		if ((errors == 0) && (assert_fails == 0)) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- sim.f
+incdir+.
mips_core_pkg.sv
control_signals.sv
alu.sv
register_file.sv
mips_datapath.sv
host_port_regs.sv
mips_core_top.sv
tb_mips_core_properties.sv
tb_mips_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_mips_core
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert --timescale 1ns/1ns -j 0
SIM_ARGS ?= +verilator+error+limit+100
PASS_MSG := SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
